/* rtl/legalizer_pkg.sv */
`default_nettype none

package legalizer_pkg;

    // ------------------------------------------------------------------
    // bus geometry
    // ------------------------------------------------------------------
    // byte address and transfer length width
    localparam int unsigned AddrWidth        = 32;
    // data bus width in bits
    localparam int unsigned DataWidth        = 32;
    // bytes per beat
    localparam int unsigned StrbWidth        = DataWidth / 8;
    // address bits inside one beat
    localparam int unsigned OffsetWidth      = $clog2(StrbWidth);

    // ------------------------------------------------------------------
    // page limits
    // ------------------------------------------------------------------
    // axi4 incr burst limit in beats
    localparam int unsigned MaxBeatsPerBurst = 256;
    // log2 of the burst limit, the page width when no reduction is asked
    localparam int unsigned DefaultLlen      = $clog2(MaxBeatsPerBurst);
    // a page never spans more than 4 KiB or 256 beats
    localparam int unsigned PageSize         = (MaxBeatsPerBurst * StrbWidth > 4096) ?
                                               4096 : MaxBeatsPerBurst * StrbWidth;
    // bits of byte offset inside the largest page
    localparam int unsigned PageAddrWidth    = $clog2(PageSize);
    // width of the reduced page length field
    localparam int unsigned LlenWidth        = 3;

    // ------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------
    typedef logic [AddrWidth-1:0]              addr_t;
    typedef logic [PageAddrWidth-1:0]          page_addr_t;
    // one bit wider so that a full page fits
    typedef logic [PageAddrWidth:0]            page_len_t;
    typedef logic [OffsetWidth-1:0]            offset_t;
    // axi len field, beats minus one
    typedef logic [DefaultLlen-1:0]            beats_t;
    typedef logic [LlenWidth-1:0]              llen_t;

endpackage : legalizer_pkg

`default_nettype wire

/* rtl/page_boundary_calc.sv */
`timescale 1ns/10ps
`default_nettype none

module page_boundary_calc (
    // use the reduced page length instead of the full page
    input  wire  logic                     reduce_len_i,
    // log2 of the reduced page length in beats
    input  wire  legalizer_pkg::llen_t      max_llen_i,
    // low address bits of the current burst
    input  wire  legalizer_pkg::page_addr_t page_addr_i,
    // bytes left before the next boundary
    output legalizer_pkg::page_len_t        bytes_to_pb_o
);

    // enough bits to count up to the full page width
    localparam int unsigned PageWidthBits = $clog2(legalizer_pkg::PageAddrWidth + 1);

    logic [PageWidthBits-1:0]   page_width;
    legalizer_pkg::page_len_t   page_size;
    legalizer_pkg::page_addr_t  page_offset;

    // ------------------------------------------------------------------
    // effective page width
    // ------------------------------------------------------------------
    always_comb begin : proc_page_width
        // beat offset bits plus the log2 of the page length in beats
        page_width = PageWidthBits'(legalizer_pkg::OffsetWidth)
                   + (reduce_len_i ? PageWidthBits'(max_llen_i)
                                   : PageWidthBits'(legalizer_pkg::DefaultLlen));
        // clamp to the largest legal page
        if (page_width > PageWidthBits'(legalizer_pkg::PageAddrWidth)) begin
            page_width = PageWidthBits'(legalizer_pkg::PageAddrWidth);
        end
    end

    // page size in bytes
    assign page_size = legalizer_pkg::page_len_t'(1) << page_width;

    // ------------------------------------------------------------------
    // offset inside the page
    // ------------------------------------------------------------------
    // variable part select done bit by bit
    always_comb begin : proc_page_offset
        page_offset = '0;
        for (int i = 0; i < legalizer_pkg::PageAddrWidth; i++) begin
            page_offset[i] = (page_width > PageWidthBits'(i)) ? page_addr_i[i] : 1'b0;
        end
    end

    // distance to the boundary, a full page when aligned
    assign bytes_to_pb_o = page_size - legalizer_pkg::page_len_t'(page_offset);

endmodule : page_boundary_calc

`default_nettype wire

/* rtl/burst_cutter.sv */
`timescale 1ns/10ps
`default_nettype none

module burst_cutter (
    input  wire  logic                      clk_i,
    input  wire  logic                      rst_i,
    // drop the remaining transfer
    input  wire  logic                      kill_i,
    // load a new transfer, wins over step and kill
    input  wire  logic                      accept_i,
    input  wire  legalizer_pkg::addr_t      load_addr_i,
    input  wire  legalizer_pkg::addr_t      load_length_i,
    // advance by one burst
    input  wire  logic                      step_i,
    // largest burst in bytes allowed at the current address
    input  wire  legalizer_pkg::page_len_t  bytes_possible_i,
    // page bits of the current address, to the boundary calculator
    output legalizer_pkg::page_addr_t       page_addr_o,
    // burst fields
    output legalizer_pkg::addr_t            addr_o,
    output legalizer_pkg::beats_t           len_o,
    output legalizer_pkg::offset_t          offset_o,
    output legalizer_pkg::offset_t          tailer_o,
    // current burst is the last one
    output logic                            done_o,
    output logic                            busy_o
);

    // remaining transfer
    legalizer_pkg::addr_t      length_d, length_q;
    legalizer_pkg::addr_t      addr_d,   addr_q;
    logic                      valid_d,  valid_q;

    // bytes of the current burst
    legalizer_pkg::page_len_t  num_bytes;
    // end of the burst counted from the aligned address
    legalizer_pkg::page_len_t  end_bytes;
    legalizer_pkg::offset_t    addr_offset;
    logic                      tf_ena;

    // ------------------------------------------------------------------
    // cut the next burst
    // ------------------------------------------------------------------
    always_comb begin : proc_cut
        // default keep state
        length_d = length_q;
        addr_d   = addr_q;
        valid_d  = valid_q;
        done_o   = 1'b0;

        if (length_q > legalizer_pkg::addr_t'(bytes_possible_i)) begin
            // more left than fits before the boundary
            num_bytes = bytes_possible_i;
            length_d  = length_q - legalizer_pkg::addr_t'(bytes_possible_i);
            addr_d    = addr_q + legalizer_pkg::addr_t'(bytes_possible_i);
        end else begin
            // rest fits in this burst
            num_bytes = length_q[legalizer_pkg::PageAddrWidth:0];
            valid_d   = 1'b0;
            done_o    = 1'b1;
        end

        // kill drops what is left
        if (kill_i) begin
            length_d = '0;
            addr_d   = '0;
            valid_d  = 1'b0;
            done_o   = 1'b1;
        end

        // refill from the request
        if (accept_i) begin
            length_d = load_length_i;
            addr_d   = load_addr_i;
            valid_d  = 1'b1;
        end
    end

    assign tf_ena = step_i | kill_i | accept_i;

    // ------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin : proc_state
        if (rst_i) begin
            length_q <= '0;
            addr_q   <= '0;
            valid_q  <= 1'b0;
        end else if (tf_ena) begin
            length_q <= length_d;
            addr_q   <= addr_d;
            valid_q  <= valid_d;
        end
    end

    // ------------------------------------------------------------------
    // burst fields
    // ------------------------------------------------------------------
    assign addr_offset = addr_q[legalizer_pkg::OffsetWidth-1:0];
    assign page_addr_o = addr_q[legalizer_pkg::PageAddrWidth-1:0];
    // burst stays inside one page, so the sum never overflows
    assign end_bytes   = num_bytes + legalizer_pkg::page_len_t'(addr_offset);

    // beat aligned start address
    assign addr_o   = {addr_q[legalizer_pkg::AddrWidth-1:legalizer_pkg::OffsetWidth],
                       {legalizer_pkg::OffsetWidth{1'b0}}};
    assign len_o    = legalizer_pkg::beats_t'((end_bytes - 1'b1) >> legalizer_pkg::OffsetWidth);
    assign offset_o = addr_offset;
    assign tailer_o = end_bytes[legalizer_pkg::OffsetWidth-1:0];
    assign busy_o   = valid_q;

    // an empty request would issue a bogus burst of 256 beats
    a_nonzero_length : assert property (@(posedge clk_i) disable iff (rst_i)
        accept_i |-> (load_length_i != '0));

endmodule : burst_cutter

`default_nettype wire

/* rtl/legalizer_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module legalizer_ctrl (
    input  wire  logic                      clk_i,
    input  wire  logic                      rst_i,
    // request and burst handshakes
    input  wire  logic                      valid_i,
    input  wire  logic                      r_ready_i,
    input  wire  logic                      w_ready_i,
    input  wire  logic                      flush_i,
    // request options
    input  wire  logic                      req_decouple_rw_i,
    input  wire  logic                      req_src_reduce_len_i,
    input  wire  logic                      req_dst_reduce_len_i,
    input  wire  legalizer_pkg::llen_t      req_src_max_llen_i,
    input  wire  legalizer_pkg::llen_t      req_dst_max_llen_i,
    // distance to each side's boundary
    input  wire  legalizer_pkg::page_len_t  r_bytes_to_pb_i,
    input  wire  legalizer_pkg::page_len_t  w_bytes_to_pb_i,
    // cutter status
    input  wire  logic                      r_done_i,
    input  wire  logic                      w_done_i,
    input  wire  logic                      r_busy_i,
    input  wire  logic                      w_busy_i,
    // registered options to the boundary calculators
    output logic                            src_reduce_len_o,
    output logic                            dst_reduce_len_o,
    output legalizer_pkg::llen_t            src_max_llen_o,
    output legalizer_pkg::llen_t            dst_max_llen_o,
    // burst limit handed back to each cutter
    output legalizer_pkg::page_len_t        r_bytes_possible_o,
    output legalizer_pkg::page_len_t        w_bytes_possible_o,
    // flow control
    output logic                            accept_o,
    output logic                            r_step_o,
    output logic                            w_step_o,
    output logic                            r_valid_o,
    output logic                            w_valid_o,
    output logic                            ready_o
);

    // options of the running transfer
    logic                  decouple_q;
    legalizer_pkg::page_len_t c_bytes_to_pb;

    always_ff @(posedge clk_i) begin : proc_opt
        if (rst_i) begin
            decouple_q       <= 1'b0;
            src_reduce_len_o <= 1'b0;
            dst_reduce_len_o <= 1'b0;
            src_max_llen_o   <= '0;
            dst_max_llen_o   <= '0;
        end else if (accept_o) begin
            decouple_q       <= req_decouple_rw_i;
            src_reduce_len_o <= req_src_reduce_len_i;
            dst_reduce_len_o <= req_dst_reduce_len_i;
            src_max_llen_o   <= req_src_max_llen_i;
            dst_max_llen_o   <= req_dst_max_llen_i;
        end
    end

    // ------------------------------------------------------------------
    // coupling
    // ------------------------------------------------------------------
    // nearer of the two boundaries
    assign c_bytes_to_pb = (r_bytes_to_pb_i > w_bytes_to_pb_i) ? w_bytes_to_pb_i
                                                               : r_bytes_to_pb_i;
    assign r_bytes_possible_o = decouple_q ? r_bytes_to_pb_i : c_bytes_to_pb;
    assign w_bytes_possible_o = decouple_q ? w_bytes_to_pb_i : c_bytes_to_pb;

    // ------------------------------------------------------------------
    // flow control
    // ------------------------------------------------------------------
    always_comb begin : proc_flow
        if (decouple_q) begin
            // each side runs on its own ready
            r_step_o = r_ready_i & !flush_i;
            w_step_o = w_ready_i & !flush_i;
        end else begin
            // both sides move together or not at all
            r_step_o = r_ready_i & w_ready_i & !flush_i;
            w_step_o = r_step_o;
        end
        r_valid_o = r_busy_i & r_step_o;
        w_valid_o = w_busy_i & w_step_o;
    end

    // new request only once both sides issue their last burst
    assign ready_o  = r_done_i & w_done_i & r_ready_i & w_ready_i & !flush_i;
    assign accept_o = ready_o & valid_i;

    // coupled sides start and finish together, so their valids agree
    a_coupled_valids : assert property (@(posedge clk_i) disable iff (rst_i)
        !decouple_q |-> (r_valid_o == w_valid_o));

endmodule : legalizer_ctrl

`default_nettype wire

/* rtl/burst_legalizer.sv */
`timescale 1ns/10ps
`default_nettype none

module burst_legalizer (
    input  wire  logic                      clk_i,
    input  wire  logic                      rst_i,
    // 1d copy request
    input  wire  legalizer_pkg::addr_t      req_length_i,
    input  wire  legalizer_pkg::addr_t      req_src_addr_i,
    input  wire  legalizer_pkg::addr_t      req_dst_addr_i,
    input  wire  logic                      req_decouple_rw_i,
    input  wire  logic                      req_src_reduce_len_i,
    input  wire  logic                      req_dst_reduce_len_i,
    input  wire  legalizer_pkg::llen_t      req_src_max_llen_i,
    input  wire  legalizer_pkg::llen_t      req_dst_max_llen_i,
    input  wire  logic                      valid_i,
    output logic                            ready_o,
    // read bursts
    output logic                            r_valid_o,
    output legalizer_pkg::addr_t            r_addr_o,
    output legalizer_pkg::beats_t           r_len_o,
    output legalizer_pkg::offset_t          r_offset_o,
    output legalizer_pkg::offset_t          r_tailer_o,
    input  wire  logic                      r_ready_i,
    // write bursts
    output logic                            w_valid_o,
    output legalizer_pkg::addr_t            w_addr_o,
    output legalizer_pkg::beats_t           w_len_o,
    output legalizer_pkg::offset_t          w_offset_o,
    output legalizer_pkg::offset_t          w_tailer_o,
    output logic                            w_last_o,
    input  wire  logic                      w_ready_i,
    // stall and abort
    input  wire  logic                      flush_i,
    input  wire  logic                      kill_i,
    output logic                            r_busy_o,
    output logic                            w_busy_o
);

    // registered options
    logic                       src_reduce_len, dst_reduce_len;
    legalizer_pkg::llen_t       src_max_llen,   dst_max_llen;
    // boundary path
    legalizer_pkg::page_addr_t  r_page_addr,    w_page_addr;
    legalizer_pkg::page_len_t   r_bytes_to_pb,  w_bytes_to_pb;
    legalizer_pkg::page_len_t   r_bytes_possible, w_bytes_possible;
    // cutter control and status
    logic                       accept, r_step, w_step;
    logic                       r_done, w_done;

    // ------------------------------------------------------------------
    // page boundaries
    // ------------------------------------------------------------------
    page_boundary_calc i_src_page (
        .reduce_len_i  ( src_reduce_len ),
        .max_llen_i    ( src_max_llen   ),
        .page_addr_i   ( r_page_addr    ),
        .bytes_to_pb_o ( r_bytes_to_pb  )
    );

    page_boundary_calc i_dst_page (
        .reduce_len_i  ( dst_reduce_len ),
        .max_llen_i    ( dst_max_llen   ),
        .page_addr_i   ( w_page_addr    ),
        .bytes_to_pb_o ( w_bytes_to_pb  )
    );

    // ------------------------------------------------------------------
    // read and write cutters
    // ------------------------------------------------------------------
    burst_cutter i_src_cut (
        .clk_i, .rst_i, .kill_i,
        .accept_i         ( accept           ),
        .load_addr_i      ( req_src_addr_i   ),
        .load_length_i    ( req_length_i     ),
        .step_i           ( r_step           ),
        .bytes_possible_i ( r_bytes_possible ),
        .page_addr_o      ( r_page_addr      ),
        .addr_o           ( r_addr_o         ),
        .len_o            ( r_len_o          ),
        .offset_o         ( r_offset_o       ),
        .tailer_o         ( r_tailer_o       ),
        .done_o           ( r_done           ),
        .busy_o           ( r_busy_o         )
    );

    burst_cutter i_dst_cut (
        .clk_i, .rst_i, .kill_i,
        .accept_i         ( accept           ),
        .load_addr_i      ( req_dst_addr_i   ),
        .load_length_i    ( req_length_i     ),
        .step_i           ( w_step           ),
        .bytes_possible_i ( w_bytes_possible ),
        .page_addr_o      ( w_page_addr      ),
        .addr_o           ( w_addr_o         ),
        .len_o            ( w_len_o          ),
        .offset_o         ( w_offset_o       ),
        .tailer_o         ( w_tailer_o       ),
        .done_o           ( w_done           ),
        .busy_o           ( w_busy_o         )
    );

    // final write burst of the transfer
    assign w_last_o = w_done;

    // ------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------
    legalizer_ctrl i_ctrl (
        .clk_i, .rst_i, .valid_i, .r_ready_i, .w_ready_i, .flush_i,
        .req_decouple_rw_i, .req_src_reduce_len_i, .req_dst_reduce_len_i,
        .req_src_max_llen_i, .req_dst_max_llen_i,
        .r_bytes_to_pb_i    ( r_bytes_to_pb    ),
        .w_bytes_to_pb_i    ( w_bytes_to_pb    ),
        .r_done_i           ( r_done           ),
        .w_done_i           ( w_done           ),
        .r_busy_i           ( r_busy_o         ),
        .w_busy_i           ( w_busy_o         ),
        .src_reduce_len_o   ( src_reduce_len   ),
        .dst_reduce_len_o   ( dst_reduce_len   ),
        .src_max_llen_o     ( src_max_llen     ),
        .dst_max_llen_o     ( dst_max_llen     ),
        .r_bytes_possible_o ( r_bytes_possible ),
        .w_bytes_possible_o ( w_bytes_possible ),
        .accept_o           ( accept           ),
        .r_step_o           ( r_step           ),
        .w_step_o           ( w_step           ),
        .r_valid_o, .w_valid_o, .ready_o
    );

endmodule : burst_legalizer

`default_nettype wire

/* tests/tb_burst_legalizer.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_burst_legalizer;

    localparam int MaxTests  = 16;
    localparam int MaxBursts = 64;

    logic                          clk_i;
    logic                          rst_i;
    legalizer_pkg::addr_t          req_length_i, req_src_addr_i, req_dst_addr_i;
    logic                          req_decouple_rw_i;
    logic                          req_src_reduce_len_i, req_dst_reduce_len_i;
    legalizer_pkg::llen_t          req_src_max_llen_i, req_dst_max_llen_i;
    logic                          valid_i, ready_o;
    logic                          r_ready_i, w_ready_i, flush_i, kill_i;
    logic                          r_valid_o, w_valid_o, w_last_o, r_busy_o, w_busy_o;
    legalizer_pkg::addr_t          r_addr_o, w_addr_o;
    legalizer_pkg::beats_t         r_len_o, w_len_o;
    legalizer_pkg::offset_t        r_offset_o, r_tailer_o, w_offset_o, w_tailer_o;

    // test records from the golden file
    string                         t_name [MaxTests];
    string                         t_mode [MaxTests];
    string                         t_rdy  [MaxTests];
    logic [31:0]                   t_opt  [MaxTests];
    legalizer_pkg::addr_t          t_len  [MaxTests];
    legalizer_pkg::addr_t          t_sa   [MaxTests];
    legalizer_pkg::addr_t          t_da   [MaxTests];
    int                            r_first [MaxTests];
    int                            r_count [MaxTests];
    int                            w_first [MaxTests];
    int                            w_count [MaxTests];
    // bursts packed as addr, len, offset, tailer
    logic [43:0]                   r_exp [MaxBursts];
    logic [43:0]                   w_exp [MaxBursts];
    int                            num_tests, num_r, num_w;

    integer                        seed = 32'ha684;
    int                            cycle_cnt   = 0;
    int                            cycle_limit = 0;
    int                            pass_cnt    = 0;
    int                            fail_cnt    = 0;
    bit                            load_ok;

    burst_legalizer i_burst_legalizer (.*);

    always #10 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // golden file reader
    // ------------------------------------------------------------------
    task automatic load_golden(output bit ok);
        int          fd, n;
        string       line, kind, name, mode, rdy;
        logic [31:0] dec, sred, sllen, dred, dllen, len, sa, da, ba, bl, bo, bt;
        ok = 1'b0;
        num_tests = 0;
        num_r = 0;
        num_w = 0;
        fd = $fopen("tests/golden_bursts.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                kind = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s", kind);
                if (kind == "test") begin
                    n = $sscanf(line, "%s %s %s %s %h %h %h %h %h %h %h %h", kind, name,
                                mode, rdy, dec, sred, sllen, dred, dllen, len, sa, da);
                    t_name[num_tests]  = name;
                    t_mode[num_tests]  = mode;
                    t_rdy[num_tests]   = rdy;
                    // decouple, src reduce, src llen, dst reduce, dst llen
                    t_opt[num_tests]   = {dec[0], sred[0], sllen[2:0], dred[0], dllen[2:0]};
                    t_len[num_tests]   = len;
                    t_sa[num_tests]    = sa;
                    t_da[num_tests]    = da;
                    r_first[num_tests] = num_r;
                    w_first[num_tests] = num_w;
                    r_count[num_tests] = 0;
                    w_count[num_tests] = 0;
                    num_tests++;
                end else if (kind == "r" || kind == "w") begin
                    n = $sscanf(line, "%s %h %h %h %h", kind, ba, bl, bo, bt);
                    if (kind == "r") begin
                        r_exp[num_r] = {ba, bl[7:0], bo[1:0], bt[1:0]};
                        num_r++;
                        r_count[num_tests-1]++;
                    end else begin
                        w_exp[num_w] = {ba, bl[7:0], bo[1:0], bt[1:0]};
                        num_w++;
                        w_count[num_tests-1]++;
                    end
                end
            end
            $fclose(fd);
            ok = (num_tests > 0);
        end
    endtask

    // compare one burst against its golden entry
    task automatic check_burst(input string test, input string side, input int idx,
                               input logic [43:0] exp_b, input logic [43:0] act_b,
                               inout int errs);
        string exp_s, act_s;
        exp_s = $sformatf("addr %h len %h off %0d tail %0d",
                          exp_b[43:12], exp_b[11:4], exp_b[3:2], exp_b[1:0]);
        act_s = $sformatf("addr %h len %h off %0d tail %0d",
                          act_b[43:12], act_b[11:4], act_b[3:2], act_b[1:0]);
        assert (exp_b === act_b) else begin
            $display("** Error %s: %s burst %0d expected %s actual %s",
                     test, side, idx, exp_s, act_s);
            errs++;
        end
    endtask

    // ------------------------------------------------------------------
    // one transfer: request, bursts, drain
    // ------------------------------------------------------------------
    task automatic run_test(input int t);
        int          r_idx, w_idx, errs, run_cnt;
        bit          accepted, finished, is_flush, is_kill, is_rand;
        logic [31:0] rnd;
        r_idx = 0;
        w_idx = 0;
        errs = 0;
        run_cnt = 0;
        accepted = 1'b0;
        finished = 1'b0;
        is_flush = (t_mode[t] == "flush");
        is_kill  = (t_mode[t] == "kill");
        is_rand  = (t_rdy[t] == "random");
        while (!finished) begin
            @(posedge clk_i);
            rnd = $random(seed);
            if (!accepted) begin
                // offer the request until it is taken
                req_length_i         <= t_len[t];
                req_src_addr_i       <= t_sa[t];
                req_dst_addr_i       <= t_da[t];
                req_decouple_rw_i    <= t_opt[t][8];
                req_src_reduce_len_i <= t_opt[t][7];
                req_src_max_llen_i   <= t_opt[t][6:4];
                req_dst_reduce_len_i <= t_opt[t][3];
                req_dst_max_llen_i   <= t_opt[t][2:0];
                valid_i              <= 1'b1;
                flush_i              <= 1'b0;
                kill_i               <= 1'b0;
                r_ready_i            <= is_rand ? (rnd[0] | rnd[1]) : 1'b1;
                w_ready_i            <= is_rand ? (rnd[2] | rnd[3]) : 1'b1;
            end else begin
                valid_i   <= 1'b0;
                // flush window in the middle of the transfer
                flush_i   <= is_flush && run_cnt >= 1 && run_cnt <= 8;
                kill_i    <= is_kill && run_cnt == 1;
                r_ready_i <= is_kill ? 1'b0 : (is_rand ? (rnd[0] | rnd[1]) : 1'b1);
                w_ready_i <= is_kill ? 1'b0 : (is_rand ? (rnd[2] | rnd[3]) : 1'b1);
                run_cnt++;
            end
            @(negedge clk_i);
            if (!accepted) begin
                accepted = valid_i && ready_o;
            end else begin
                assert (!(flush_i && (r_valid_o || w_valid_o || ready_o))) else begin
                    $display("%s: valid or ready seen while flush is high", t_name[t]);
                    errs++;
                end
                // kill clears both sides on the edge that samples it
                assert (!(is_kill && run_cnt == 3 && (r_busy_o || w_busy_o))) else begin
                    $display("%s: a side is still busy the cycle after kill", t_name[t]);
                    errs++;
                end
                // no new request while a side still has bursts to go
                assert (!(ready_o && ((r_busy_o && r_count[t] - r_idx > 1) ||
                                      (w_busy_o && w_count[t] - w_idx > 1)))) else begin
                    $display("%s: ready_o high with bursts still pending", t_name[t]);
                    errs++;
                end
                if (r_valid_o) begin
                    assert (r_idx < r_count[t]) else begin
                        $display("%s: read burst at %h was not expected", t_name[t], r_addr_o);
                        errs++;
                    end
                    if (r_idx < r_count[t]) begin
                        check_burst(t_name[t], "read", r_idx, r_exp[r_first[t] + r_idx],
                                    {r_addr_o, r_len_o, r_offset_o, r_tailer_o}, errs);
                    end
                    r_idx++;
                end
                if (w_valid_o) begin
                    assert (w_idx < w_count[t]) else begin
                        $display("%s: write burst at %h was not expected", t_name[t], w_addr_o);
                        errs++;
                    end
                    if (w_idx < w_count[t]) begin
                        check_burst(t_name[t], "write", w_idx, w_exp[w_first[t] + w_idx],
                                    {w_addr_o, w_len_o, w_offset_o, w_tailer_o}, errs);
                        assert (w_last_o === (w_idx == w_count[t] - 1)) else begin
                            $display("** Error %s: w_last on burst %0d expected %0d actual %0d",
                                     t_name[t], w_idx, (w_idx == w_count[t] - 1), w_last_o);
                            errs++;
                        end
                    end
                    w_idx++;
                end
                finished = !r_busy_o && !w_busy_o;
            end
        end
        assert (r_idx >= r_count[t] && w_idx >= w_count[t]) else begin
            $display("%s: transfer ended with %0d read and %0d write bursts missing",
                     t_name[t], r_count[t] - r_idx, w_count[t] - w_idx);
            errs++;
        end
        if (errs == 0) begin
            $display("test %s: ok, %0d read and %0d write bursts", t_name[t], r_idx, w_idx);
            pass_cnt++;
        end else begin
            $display("test %s: %0d errors", t_name[t], errs);
            fail_cnt++;
        end
    endtask

    // ------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------
    initial begin
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
        $display("Result: FAILED");
        $finish;
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        req_length_i = '0;
        req_src_addr_i = '0;
        req_dst_addr_i = '0;
        req_decouple_rw_i = 1'b0;
        req_src_reduce_len_i = 1'b0;
        req_dst_reduce_len_i = 1'b0;
        req_src_max_llen_i = '0;
        req_dst_max_llen_i = '0;
        valid_i = 1'b0;
        r_ready_i = 1'b0;
        w_ready_i = 1'b0;
        flush_i = 1'b0;
        kill_i = 1'b0;
        load_golden(load_ok);
        if (!load_ok) begin
            $display("could not read any test from tests/golden_bursts.txt");
            $display("Result: FAILED");
        end else begin
            // budget of 64 cycles per golden burst plus setup
            cycle_limit = 64 * (num_r + num_w) + 200;
            repeat (4) @(posedge clk_i);
            rst_i <= 1'b0;
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
            $display("%0d tests, %0d passed, %0d failed", num_tests, pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
        end
        $finish;
    end

endmodule : tb_burst_legalizer

`default_nettype wire

/* tests/golden_bursts.txt */
# test <name> <mode> <ready> <decouple> <src_reduce> <src_llen> <dst_reduce> <dst_llen> <length> <src_addr> <dst_addr>
# r|w <addr> <len> <offset> <tailer>   bursts in issue order, numbers in hex
test coupled_split normal full 0 0 0 0 0 00000a00 00001100 00020000
r 00001100 bf 0 0
r 00001400 3f 0 0
r 00001500 bf 0 0
r 00001800 3f 0 0
r 00001900 7f 0 0
w 00020000 bf 0 0
w 00020300 3f 0 0
w 00020400 bf 0 0
w 00020700 3f 0 0
w 00020800 7f 0 0
test reduced_offsets normal full 0 1 4 1 5 000000c5 00003007 0000410a
r 00003004 0e 3 0
r 00003040 0f 0 1
r 0000307c 00 1 0
r 00003080 0f 0 0
r 000030c0 02 0 0
w 00004108 0e 2 3
w 00004140 0f 3 0
w 00004180 00 0 3
w 00004180 10 3 3
w 000041c0 03 3 3
test decoupled_random normal random 1 0 0 1 6 00000300 00005200 00006080
r 00005200 7f 0 0
r 00005400 3f 0 0
w 00006080 1f 0 0
w 00006100 3f 0 0
w 00006200 3f 0 0
w 00006300 1f 0 0
test flush_hold flush full 0 0 0 0 0 00000800 00008000 00009200
r 00008000 7f 0 0
r 00008200 7f 0 0
r 00008400 7f 0 0
r 00008600 7f 0 0
w 00009200 7f 0 0
w 00009400 7f 0 0
w 00009600 7f 0 0
w 00009800 7f 0 0
test kill_drop kill full 0 0 0 0 0 00000400 0000a000 0000b000
test after_kill normal full 0 0 0 0 0 000001f3 0000c3f2 0000d001
r 0000c3f0 03 2 0
r 0000c400 79 0 1
w 0000d000 03 1 3
w 0000d00c 79 3 0
test backpressure normal random 0 0 0 0 0 000001f3 0000c3f2 0000d001
r 0000c3f0 03 2 0
r 0000c400 79 0 1
w 0000d000 03 1 3
w 0000d00c 79 3 0

/* sim.f */
rtl/legalizer_pkg.sv
rtl/page_boundary_calc.sv
rtl/burst_cutter.sv
rtl/legalizer_ctrl.sv
rtl/burst_legalizer.sv
tests/tb_burst_legalizer.sv

/* Bender.yml */
package:
  name: burst_legalizer

sources:
  - rtl/legalizer_pkg.sv
  - rtl/page_boundary_calc.sv
  - rtl/burst_cutter.sv
  - rtl/legalizer_ctrl.sv
  - rtl/burst_legalizer.sv
  - target: test
    files:
      - tests/tb_burst_legalizer.sv
